/* Makefile */
# Verilator build and run for the dual-issue register file

VERILATOR ?= verilator
TOP       ?= tb_regfile_dual_issue
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# build, run, then decide on the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* filelist.f */
+incdir+.
rf_pkg.sv
rf_bank_2r1w.sv
rf_live_value_table.sv
rf_read_lane.sv
regfile_dual_issue.sv
tb_regfile_dual_issue.sv

/* regfile_dual_issue.sv */
//------------------------------------------------------------
// dual-issue integer register file, two write ports and
// four asynchronous read ports in a banked organization
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module regfile_dual_issue
(
    // clock and reset
     input  logic                 clk_i
    ,input  logic                 rst_i

    // write back, lane 1 is the younger instruction
    ,input  rf_pkg::rf_write_t    wr0_i
    ,input  rf_pkg::rf_write_t    wr1_i

    // operand requests, one pair per lane
    ,input  rf_pkg::rf_read_req_t rd_req0_i
    ,input  rf_pkg::rf_read_req_t rd_req1_i

    // operand values, same cycle as the request
    ,output rf_pkg::rf_read_rsp_t rd_rsp0_o
    ,output rf_pkg::rf_read_rsp_t rd_rsp1_o
);

// shared bank select for both lanes
rf_pkg::rf_lvt_t lvt;

//------------------------------------------------------------
// live value table
//------------------------------------------------------------
rf_live_value_table u_lvt
(
     .clk_i (clk_i)
    ,.rst_i (rst_i)
    ,.wr0_i (wr0_i)
    ,.wr1_i (wr1_i)
    ,.lvt_o (lvt)
);

//------------------------------------------------------------
// read lanes
//------------------------------------------------------------
// lane 0 operands
rf_read_lane u_lane0
(
     .clk_i (clk_i)
    ,.rst_i (rst_i)
    ,.wr0_i (wr0_i)
    ,.wr1_i (wr1_i)
    ,.lvt_i (lvt)
    ,.req_i (rd_req0_i)
    ,.rsp_o (rd_rsp0_o)
);

// lane 1 operands, its own copy of both banks
rf_read_lane u_lane1
(
     .clk_i (clk_i)
    ,.rst_i (rst_i)
    ,.wr0_i (wr0_i)
    ,.wr1_i (wr1_i)
    ,.lvt_i (lvt)
    ,.req_i (rd_req1_i)
    ,.rsp_o (rd_rsp1_o)
);

endmodule

`default_nettype wire

/* rf_bank_2r1w.sv */
//------------------------------------------------------------
// flop based register bank, one write port and two
// asynchronous read ports, x0 hardwired to zero
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rf_settings.svh"

module rf_bank_2r1w
(
    // clock and reset
     input  logic                 clk_i
    ,input  logic                 rst_i

    // write port
    ,input  rf_pkg::rf_write_t    wr_i

    // read pair
    ,input  rf_pkg::rf_read_req_t req_i
    ,output rf_pkg::rf_read_rsp_t rsp_o
);

//------------------------------------------------------------
// storage
//------------------------------------------------------------
// x0 has no flops, entries 1 to 31 only
logic [`RF_NUM_REGS-1:1][`RF_XLEN-1:0] regs_q;

always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        regs_q <= '0;
    end
    else if (wr_i.rd != '0)
    begin
        regs_q[wr_i.rd] <= wr_i.value;
    end
end

//------------------------------------------------------------
// asynchronous read
//------------------------------------------------------------
always_comb
begin
    rsp_o = '0;

    if (req_i.ra != '0)
    begin
        rsp_o.ra_value = regs_q[req_i.ra];
    end

    if (req_i.rb != '0)
    begin
        rsp_o.rb_value = regs_q[req_i.rb];
    end
end

//------------------------------------------------------------
// checks
//------------------------------------------------------------
// rd of zero is a bubble, no entry may change on that edge
a_x0_write_ignored : assert property
(
    @(posedge clk_i) disable iff (rst_i)
    (wr_i.rd == '0) |=> $stable(regs_q)
)
else
    $error("bank changed on a write to x0");

endmodule

`default_nettype wire

/* rf_live_value_table.sv */
//------------------------------------------------------------
// live value table holding one bit per register that names
// the write port which last wrote it
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rf_live_value_table
(
    // clock and reset
     input  logic              clk_i
    ,input  logic              rst_i

    // both write ports
    ,input  rf_pkg::rf_write_t wr0_i
    ,input  rf_pkg::rf_write_t wr1_i

    // per-register bank select to every read lane
    ,output rf_pkg::rf_lvt_t   lvt_o
);

rf_pkg::rf_lvt_t lvt_q;
rf_pkg::rf_lvt_t lvt_d;

//------------------------------------------------------------
// next state
//------------------------------------------------------------
always_comb
begin
    lvt_d = lvt_q;

    // port 0 first and port 1 overrides on a collision
    lvt_d[wr0_i.rd] = 1'b0;
    lvt_d[wr1_i.rd] = 1'b1;

    // x0 is never live in bank 1
    lvt_d[0] = 1'b0;
end

always_ff @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        lvt_q <= '0;
    end
    else
    begin
        lvt_q <= lvt_d;
    end
end

assign lvt_o = lvt_q;

//------------------------------------------------------------
// checks
//------------------------------------------------------------
// x0 must always select bank 0 in every lane
a_x0_bank0 : assert property
(
    @(posedge clk_i) disable iff (rst_i)
    !lvt_o[0]
)
else
    $error("live value table marks x0 as bank 1");

endmodule

`default_nettype wire

/* rf_pkg.sv */
//------------------------------------------------------------
// packed port types for the dual-issue register file
//------------------------------------------------------------
`default_nettype none

`include "rf_settings.svh"

package rf_pkg;

    // one write port, rd of zero means no write
    typedef struct packed
    {
        logic [`RF_ADDR_W-1:0] rd;
        logic [`RF_XLEN-1:0]   value;
    } rf_write_t;

    // source operand indices for one lane
    typedef struct packed
    {
        logic [`RF_ADDR_W-1:0] ra;
        logic [`RF_ADDR_W-1:0] rb;
    } rf_read_req_t;

    // operand values for one lane
    typedef struct packed
    {
        logic [`RF_XLEN-1:0] ra_value;
        logic [`RF_XLEN-1:0] rb_value;
    } rf_read_rsp_t;

    // set bit -> bank of write port 1 holds the live copy
    typedef logic [`RF_NUM_REGS-1:0] rf_lvt_t;

endpackage

`default_nettype wire

/* rf_read_lane.sv */
//------------------------------------------------------------
// one read lane, a bank per write port plus live value
// selection for the lane's ra/rb pair
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module rf_read_lane
(
    // clock and reset
     input  logic                 clk_i
    ,input  logic                 rst_i

    // write ports, one per bank
    ,input  rf_pkg::rf_write_t    wr0_i
    ,input  rf_pkg::rf_write_t    wr1_i

    // bank select from the live value table
    ,input  rf_pkg::rf_lvt_t      lvt_i

    // read pair for this lane
    ,input  rf_pkg::rf_read_req_t req_i
    ,output rf_pkg::rf_read_rsp_t rsp_o
);

rf_pkg::rf_read_rsp_t bank0_rsp;
rf_pkg::rf_read_rsp_t bank1_rsp;

//------------------------------------------------------------
// banks
//------------------------------------------------------------
// bank 0 follows write port 0
rf_bank_2r1w u_bank0
(
     .clk_i (clk_i)
    ,.rst_i (rst_i)
    ,.wr_i  (wr0_i)
    ,.req_i (req_i)
    ,.rsp_o (bank0_rsp)
);

// bank 1 follows write port 1
rf_bank_2r1w u_bank1
(
     .clk_i (clk_i)
    ,.rst_i (rst_i)
    ,.wr_i  (wr1_i)
    ,.req_i (req_i)
    ,.rsp_o (bank1_rsp)
);

//------------------------------------------------------------
// live value select
//------------------------------------------------------------
always_comb
begin
    rsp_o.ra_value = lvt_i[req_i.ra] ? bank1_rsp.ra_value : bank0_rsp.ra_value;
    rsp_o.rb_value = lvt_i[req_i.rb] ? bank1_rsp.rb_value : bank0_rsp.rb_value;
end

//------------------------------------------------------------
// checks
//------------------------------------------------------------
// x0 reads zero through both the table and the banks
a_ra_x0_zero : assert property
(
    @(posedge clk_i) disable iff (rst_i)
    (req_i.ra == '0) |-> (rsp_o.ra_value == '0)
)
else
    $error("lane ra read of x0 not zero: %h", rsp_o.ra_value);

a_rb_x0_zero : assert property
(
    @(posedge clk_i) disable iff (rst_i)
    (req_i.rb == '0) |-> (rsp_o.rb_value == '0)
)
else
    $error("lane rb read of x0 not zero: %h", rsp_o.rb_value);

endmodule

`default_nettype wire

/* rf_settings.svh */
//------------------------------------------------------------
// register file sizing macros shared by the package and RTL
//------------------------------------------------------------
`ifndef RF_SETTINGS_SVH
`define RF_SETTINGS_SVH

// data width of one architectural register
`define RF_XLEN      32

// width of a register index (ra, rb, rd)
`define RF_ADDR_W    5

// architectural registers, x0 included
`define RF_NUM_REGS  32

`endif

/* tb_regfile_dual_issue.sv */
//------------------------------------------------------------
// testbench for the dual-issue register file with a model,
// LFSR stimulus and concurrent checks on all read ports
//------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "rf_settings.svh"

module tb_regfile_dual_issue;

// cycles a written value may take to reach the read ports
localparam int          WAIT_LIMIT    = 8;
localparam int          RANDOM_CYCLES = 400;
localparam logic [15:0] LFSR_SEED     = 16'd62827;

logic clk_i;
logic rst_i;

rf_pkg::rf_write_t    wr0;
rf_pkg::rf_write_t    wr1;
rf_pkg::rf_read_req_t rd_req0;
rf_pkg::rf_read_req_t rd_req1;
rf_pkg::rf_read_rsp_t rd_rsp0;
rf_pkg::rf_read_rsp_t rd_rsp1;

// architectural state as seen after the last edge
logic [`RF_NUM_REGS-1:0][`RF_XLEN-1:0] model_q;
rf_pkg::rf_read_rsp_t                  exp_rsp0;
rf_pkg::rf_read_rsp_t                  exp_rsp1;

logic [15:0] lfsr_q;
int          error_count;
int          timeout_count;
int          check_count;

//------------------------------------------------------------
// DUT
//------------------------------------------------------------
regfile_dual_issue uut
(
     .clk_i     (clk_i)
    ,.rst_i     (rst_i)
    ,.wr0_i     (wr0)
    ,.wr1_i     (wr1)
    ,.rd_req0_i (rd_req0)
    ,.rd_req1_i (rd_req1)
    ,.rd_rsp0_o (rd_rsp0)
    ,.rd_rsp1_o (rd_rsp1)
);

always #5 clk_i = ~clk_i;

//------------------------------------------------------------
// reference model
//------------------------------------------------------------
always @(posedge clk_i or posedge rst_i)
begin
    if (rst_i)
    begin
        model_q <= '0;
    end
    else
    begin
        // x0 is never written, lane 1 lands last and wins
        if (wr0.rd != '0)
        begin
            model_q[wr0.rd] <= wr0.value;
        end
        if (wr1.rd != '0)
        begin
            model_q[wr1.rd] <= wr1.value;
        end
    end
end

always_comb
begin
    exp_rsp0.ra_value = (rd_req0.ra == '0) ? '0 : model_q[rd_req0.ra];
    exp_rsp0.rb_value = (rd_req0.rb == '0) ? '0 : model_q[rd_req0.rb];
    exp_rsp1.ra_value = (rd_req1.ra == '0) ? '0 : model_q[rd_req1.ra];
    exp_rsp1.rb_value = (rd_req1.rb == '0) ? '0 : model_q[rd_req1.rb];
end

//------------------------------------------------------------
// checks, half a cycle after each edge
//------------------------------------------------------------
a_rsp0_ra : assert property
(
    @(negedge clk_i) disable iff (rst_i)
    rd_rsp0.ra_value == exp_rsp0.ra_value
)
else
begin
    error_count = error_count + 1;
    $display("Error: rd_rsp0_o.ra_value got %h expected %h (ra %h)",
        rd_rsp0.ra_value, exp_rsp0.ra_value, rd_req0.ra);
end

a_rsp0_rb : assert property
(
    @(negedge clk_i) disable iff (rst_i)
    rd_rsp0.rb_value == exp_rsp0.rb_value
)
else
begin
    error_count = error_count + 1;
    $display("Error: rd_rsp0_o.rb_value got %h expected %h (rb %h)",
        rd_rsp0.rb_value, exp_rsp0.rb_value, rd_req0.rb);
end

a_rsp1_ra : assert property
(
    @(negedge clk_i) disable iff (rst_i)
    rd_rsp1.ra_value == exp_rsp1.ra_value
)
else
begin
    error_count = error_count + 1;
    $display("Error: rd_rsp1_o.ra_value got %h expected %h (ra %h)",
        rd_rsp1.ra_value, exp_rsp1.ra_value, rd_req1.ra);
end

a_rsp1_rb : assert property
(
    @(negedge clk_i) disable iff (rst_i)
    rd_rsp1.rb_value == exp_rsp1.rb_value
)
else
begin
    error_count = error_count + 1;
    $display("Error: rd_rsp1_o.rb_value got %h expected %h (rb %h)",
        rd_rsp1.rb_value, exp_rsp1.rb_value, rd_req1.rb);
end

always @(negedge clk_i)
begin
    if (!rst_i)
    begin
        check_count = check_count + 4;
    end
end

//------------------------------------------------------------
// helpers
//------------------------------------------------------------
// x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    begin
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    end
endfunction

// one LFSR step per bit taken
task automatic random_bits(input int width, output logic [31:0] bits);
    begin
        bits = '0;
        for (int i = 0; i < width; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            bits = {bits[30:0], lfsr_q[0]};
        end
    end
endtask

task automatic random_write(output rf_pkg::rf_write_t w);
    logic [31:0] bits;
    begin
        random_bits(`RF_ADDR_W, bits);
        w.rd = bits[`RF_ADDR_W-1:0];
        random_bits(`RF_XLEN, bits);
        w.value = bits;
    end
endtask

task automatic random_req(output rf_pkg::rf_read_req_t q);
    logic [31:0] bits;
    begin
        random_bits(`RF_ADDR_W, bits);
        q.ra = bits[`RF_ADDR_W-1:0];
        random_bits(`RF_ADDR_W, bits);
        q.rb = bits[`RF_ADDR_W-1:0];
    end
endtask

function automatic rf_pkg::rf_write_t make_write(input logic [`RF_ADDR_W-1:0] rd,
                                                input logic [`RF_XLEN-1:0]   value);
    rf_pkg::rf_write_t w;
    begin
        w.rd    = rd;
        w.value = value;
        return w;
    end
endfunction

function automatic rf_pkg::rf_read_req_t make_req(input logic [`RF_ADDR_W-1:0] ra,
                                                  input logic [`RF_ADDR_W-1:0] rb);
    rf_pkg::rf_read_req_t q;
    begin
        q.ra = ra;
        q.rb = rb;
        return q;
    end
endfunction

// present one cycle of inputs on the next rising edge
task automatic drive_cycle(input rf_pkg::rf_write_t    w0,
                           input rf_pkg::rf_write_t    w1,
                           input rf_pkg::rf_read_req_t q0,
                           input rf_pkg::rf_read_req_t q1);
    begin
        @(posedge clk_i);
        wr0     <= w0;
        wr1     <= w1;
        rd_req0 <= q0;
        rd_req1 <= q1;
    end
endtask

// point all four ports at one register until the value shows
task automatic wait_visible(input logic [`RF_ADDR_W-1:0] idx,
                            input logic [`RF_XLEN-1:0]   value);
    int n;
    bit seen;
    begin
        n    = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_LIMIT)
        begin
            drive_cycle('0, '0, make_req(idx, idx), make_req(idx, idx));
            @(negedge clk_i);
            seen = (rd_rsp0.ra_value == value) && (rd_rsp0.rb_value == value) &&
                   (rd_rsp1.ra_value == value) && (rd_rsp1.rb_value == value);
            n = n + 1;
        end
        if (!seen)
        begin
            timeout_count = timeout_count + 1;
            $display("Timeout: register x%0d did not show value %h on all ports in %0d cycles",
                idx, value, WAIT_LIMIT);
        end
    end
endtask

//------------------------------------------------------------
// stimulus
//------------------------------------------------------------
initial
begin
    rf_pkg::rf_write_t    rw0;
    rf_pkg::rf_write_t    rw1;
    rf_pkg::rf_read_req_t rq0;
    rf_pkg::rf_read_req_t rq1;
    logic [`RF_ADDR_W-1:0] idx;

    clk_i         = 1'b0;
    rst_i         = 1'b1;
    wr0           = '0;
    wr1           = '0;
    rd_req0       = '0;
    rd_req1       = '0;
    lfsr_q        = LFSR_SEED;
    error_count   = 0;
    timeout_count = 0;
    check_count   = 0;

    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    // every index reads zero out of reset
    for (int i = 0; i < `RF_NUM_REGS; i++)
    begin
        idx = i[`RF_ADDR_W-1:0];
        drive_cycle('0, '0, make_req(idx, ~idx), make_req(~idx, idx));
    end

    // lane 0 write
    drive_cycle(make_write(5'd5, 32'h1234_5678), '0, '0, '0);
    wait_visible(5'd5, 32'h1234_5678);

    // lane 1 write, then lane 0 takes the register back
    drive_cycle('0, make_write(5'd7, 32'ha5a5_0007), '0, '0);
    wait_visible(5'd7, 32'ha5a5_0007);
    drive_cycle(make_write(5'd7, 32'h5a5a_7000), '0, '0, '0);
    wait_visible(5'd7, 32'h5a5a_7000);

    // same register from both lanes in one cycle
    drive_cycle(make_write(5'd9, 32'h0000_c0c0), make_write(5'd9, 32'hd1d1_0009), '0, '0);
    wait_visible(5'd9, 32'hd1d1_0009);

    // x0 writes from both lanes, alone and beside a real write
    drive_cycle(make_write(5'd0, 32'hdead_beef), make_write(5'd0, 32'hcafe_f00d), '0, '0);
    wait_visible(5'd0, 32'h0);
    drive_cycle(make_write(5'd0, 32'h1111_1111), make_write(5'd12, 32'h2222_2222), '0, '0);
    wait_visible(5'd12, 32'h2222_2222);
    drive_cycle(make_write(5'd12, 32'h3333_3333), make_write(5'd0, 32'h4444_4444), '0, '0);
    wait_visible(5'd12, 32'h3333_3333);
    wait_visible(5'd0, 32'h0);

    // random traffic on both lanes
    for (int n = 0; n < RANDOM_CYCLES; n++)
    begin
        random_write(rw0);
        random_write(rw1);
        random_req(rq0);
        random_req(rq1);
        drive_cycle(rw0, rw1, rq0, rq1);
    end

    // final sweep over the whole file
    for (int i = 0; i < `RF_NUM_REGS; i++)
    begin
        idx = i[`RF_ADDR_W-1:0];
        drive_cycle('0, '0, make_req(idx, ~idx), make_req(~idx, idx));
    end
    @(negedge clk_i);

    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0)
    begin
        $display("=== PASS ===");
    end
    else
    begin
        $display("=== FAIL ===");
    end
    $finish;
end

endmodule

`default_nettype wire
